/* Makefile */
VERILATOR  ?= verilator
FILELIST   ?= tb.f
TOP        ?= exu_tb
RTL_TOP    ?= exu_top
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= design/exu_pkg.sv design/exu_alu.sv design/exu_muldiv.sv \
              design/exu_decode.sv design/exu_execute.sv design/exu_wb_slave.sv \
              design/exu_top.sv
PASS_MSG   ?= Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -Idesign $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* design/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu
(
    input  exu_pkg::exu_op_e    i_op,
    input  logic [31:0]         i_op1,
    input  logic [31:0]         i_op2,
    output logic [31:0]         o_result
);

    logic           sub;
    logic [32:0]    sum;
    logic           lts;
    logic           ltu;
    logic [4:0]     shamt;

    // ==========================================================
    // Adder, shared by add, subtract and both compares.
    // ==========================================================
    assign sub = i_op inside {exu_pkg::SUB, exu_pkg::SLT, exu_pkg::SLTU};
    assign sum = {1'b0, i_op1} + {1'b0, i_op2 ^ {32{sub}}} + 33'(sub);

    // No carry out of op1 - op2 means a borrow.
    assign ltu = ~sum[32];
    assign lts = (i_op1[31] ^ i_op2[31]) ? i_op1[31] : sum[31];

    assign shamt = i_op2[4:0];

    always_comb
    begin
        case (i_op)
        exu_pkg::ADD,
        exu_pkg::SUB:  o_result = sum[31:0];
        exu_pkg::SLT:  o_result = {31'd0, lts};
        exu_pkg::SLTU: o_result = {31'd0, ltu};
        exu_pkg::XOR:  o_result = i_op1 ^ i_op2;
        exu_pkg::OR:   o_result = i_op1 | i_op2;
        exu_pkg::AND:  o_result = i_op1 & i_op2;
        exu_pkg::SLL:  o_result = i_op1 << shamt;
        exu_pkg::SRL:  o_result = i_op1 >> shamt;
        exu_pkg::SRA:  o_result = $signed(i_op1) >>> shamt;
        default:       o_result = '0;
        endcase
    end

endmodule

/* design/exu_decode.sv */
`timescale 1ns/1ps

module exu_decode
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  exu_pkg::exu_issue_t     i_issue,
    output exu_pkg::exu_ctrl_t      o_ctrl
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    exu_pkg::exu_instr_u    instr;
    exu_pkg::exu_op_e       base_op;
    exu_pkg::exu_op_e       op;
    logic [31:0]            op2;
    logic                   valid_q;
    exu_pkg::exu_op_e       op_q;
    logic [31:0]            op1_q;
    logic [31:0]            op2_q;

    assign instr = i_issue.instr;

    // Operation for funct7 == 0, shared by OP and OP-IMM.
    always_comb
    begin
        case (instr.r.funct3)
        3'd0:    base_op = exu_pkg::ADD;
        3'd1:    base_op = exu_pkg::SLL;
        3'd2:    base_op = exu_pkg::SLT;
        3'd3:    base_op = exu_pkg::SLTU;
        3'd4:    base_op = exu_pkg::XOR;
        3'd5:    base_op = exu_pkg::SRL;
        3'd6:    base_op = exu_pkg::OR;
        default: base_op = exu_pkg::AND;
        endcase
    end

    always_comb
    begin
        op  = exu_pkg::ILLEGAL;
        op2 = i_issue.op2;
        case (instr.r.opcode)
        OPC_OP:
        begin
            if (instr.r.funct7 == F7_MULDIV)
            begin
                case (instr.r.funct3)
                3'd0:    op = exu_pkg::MUL;
                3'd1:    op = exu_pkg::MULH;
                3'd2:    op = exu_pkg::MULHSU;
                3'd3:    op = exu_pkg::MULHU;
                3'd4:    op = exu_pkg::DIV;
                3'd5:    op = exu_pkg::DIVU;
                3'd6:    op = exu_pkg::REM;
                default: op = exu_pkg::REMU;
                endcase
            end
            else if (instr.r.funct7 == F7_BASE)
                op = base_op;
            else if (instr.r.funct7 == F7_ALT && instr.r.funct3 == 3'd0)
                op = exu_pkg::SUB;
            else if (instr.r.funct7 == F7_ALT && instr.r.funct3 == 3'd5)
                op = exu_pkg::SRA;
        end
        OPC_OP_IMM:
        begin
            op2 = {{20{instr.i.imm[11]}}, instr.i.imm};
            if (instr.i.funct3 == 3'd1 || instr.i.funct3 == 3'd5)
            begin
                // Shamt sits in the rs2 slot; bit 30 selects SRAI.
                op2 = {27'd0, instr.r.rs2};
                if (instr.r.funct7 == F7_BASE)
                    op = base_op;
                else if (instr.r.funct7 == F7_ALT && instr.i.funct3 == 3'd5)
                    op = exu_pkg::SRA;
            end
            else
                op = base_op;
        end
        default:
            op = exu_pkg::ILLEGAL;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            valid_q <= 1'b0;
        else
            valid_q <= i_issue.valid;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_issue.valid)
        begin
            op_q  <= op;
            op1_q <= i_issue.op1;
            op2_q <= op2;
        end
    end

    always_comb
    begin
        o_ctrl.valid = valid_q;
        o_ctrl.op    = op_q;
        o_ctrl.op1   = op1_q;
        o_ctrl.op2   = op2_q;
    end

endmodule

/* design/exu_defines.svh */
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Data path width.
`define EXU_XLEN        32

// Wishbone register map, byte offsets.
`define EXU_REG_OP1     4'h0
`define EXU_REG_OP2     4'h4
`define EXU_REG_INSTR   4'h8
`define EXU_REG_RESULT  4'hC

// One iteration per operand bit.
`define EXU_MD_STEPS    32

`endif

/* design/exu_execute.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_execute
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  exu_pkg::exu_ctrl_t      i_ctrl,
    output exu_pkg::exu_res_t       o_res
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_e;

    state_e                 state;
    logic                   is_md;
    logic                   alu_take;
    logic                   md_start;
    logic                   md_done;
    logic                   res_valid;
    logic [`EXU_XLEN-1:0]   alu_result;
    logic [`EXU_XLEN-1:0]   md_result;
    logic [`EXU_XLEN-1:0]   res_q;

    assign is_md = i_ctrl.op inside {exu_pkg::MUL, exu_pkg::MULH, exu_pkg::MULHSU,
                                     exu_pkg::MULHU, exu_pkg::DIV, exu_pkg::DIVU,
                                     exu_pkg::REM, exu_pkg::REMU};

    assign alu_take = (state == IDLE) & i_ctrl.valid & ~is_md;
    assign md_start = (state == IDLE) & i_ctrl.valid & is_md;

    exu_alu u_alu
    (
        .i_op       (i_ctrl.op),
        .i_op1      (i_ctrl.op1),
        .i_op2      (i_ctrl.op2),
        .o_result   (alu_result)
    );

    exu_muldiv u_muldiv
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_start    (md_start),
        .i_op       (i_ctrl.op),
        .i_op1      (i_ctrl.op1),
        .i_op2      (i_ctrl.op2),
        .o_done     (md_done),
        .o_result   (md_result)
    );

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state     <= IDLE;
            res_valid <= 1'b0;
        end
        else
        begin
            res_valid <= alu_take | ((state == WAIT) & md_done);
            case (state)
            IDLE:    if (md_start) state <= WAIT;
            WAIT:    if (md_done) state <= IDLE;
            default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (alu_take)
            res_q <= alu_result;
        else if (md_done)
            res_q <= md_result;
    end

    always_comb
    begin
        o_res.valid  = res_valid;
        o_res.result = res_q;
    end

    // The bus front end holds new work until the result is out.
    a_no_ctrl_in_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == WAIT) |-> !i_ctrl.valid);

endmodule

/* design/exu_muldiv.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_muldiv
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  exu_pkg::exu_op_e        i_op,
    input  logic [`EXU_XLEN-1:0]    i_op1,
    input  logic [`EXU_XLEN-1:0]    i_op2,
    output logic                    o_done,
    output logic [`EXU_XLEN-1:0]    o_result
);

    localparam int XLEN  = `EXU_XLEN;
    localparam int CNT_W = $clog2(`EXU_MD_STEPS);

    logic                   op1_signed;
    logic                   op2_signed;
    logic                   is_div;
    logic                   op1_neg;
    logic                   op2_neg;
    logic [XLEN-1:0]        op1_mag;
    logic [XLEN-1:0]        op2_mag;
    logic                   running;
    logic [CNT_W-1:0]       cnt;
    exu_pkg::exu_op_e       op_q;
    logic                   div_q;
    logic                   neg_q;
    logic                   rem_neg_q;
    logic [XLEN-1:0]        acc;
    logic [XLEN-1:0]        lo;
    logic [XLEN-1:0]        mcand;
    logic [XLEN:0]          mul_sum;
    logic [XLEN:0]          div_shift;
    logic [XLEN+1:0]        div_trial;
    logic                   div_ge;
    logic [2*XLEN-1:0]      prod;
    logic [XLEN-1:0]        quo;
    logic [XLEN-1:0]        rem;

    assign op1_signed = i_op inside {exu_pkg::MULH, exu_pkg::MULHSU, exu_pkg::DIV, exu_pkg::REM};
    assign op2_signed = i_op inside {exu_pkg::MULH, exu_pkg::DIV, exu_pkg::REM};
    assign is_div     = i_op inside {exu_pkg::DIV, exu_pkg::DIVU, exu_pkg::REM, exu_pkg::REMU};

    assign op1_neg = op1_signed & i_op1[XLEN-1];
    assign op2_neg = op2_signed & i_op2[XLEN-1];
    assign op1_mag = op1_neg ? -i_op1 : i_op1;
    assign op2_mag = op2_neg ? -i_op2 : i_op2;

    // ==========================================================
    // One step per cycle, for both multiply and divide.
    // ==========================================================
    assign mul_sum   = {1'b0, acc} + (lo[0] ? {1'b0, mcand} : '0);
    assign div_shift = {acc, lo[XLEN-1]};
    assign div_trial = {1'b0, div_shift} - {2'b00, mcand};
    assign div_ge    = ~div_trial[XLEN+1];

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            running <= 1'b0;
            cnt     <= '0;
            o_done  <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                running <= 1'b1;
                cnt     <= '0;
            end
            else if (running)
            begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(`EXU_MD_STEPS - 1))
                begin
                    running <= 1'b0;
                    o_done  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_start)
        begin
            op_q      <= i_op;
            div_q     <= is_div;
            // Divide by zero keeps the all-ones quotient unsigned.
            neg_q     <= (op1_neg ^ op2_neg) & ~(is_div & (i_op2 == '0));
            rem_neg_q <= op1_neg;
            acc       <= '0;
            lo        <= is_div ? op1_mag : op2_mag;
            mcand     <= is_div ? op2_mag : op1_mag;
        end
        else if (running)
        begin
            if (div_q)
            begin
                acc <= div_ge ? div_trial[XLEN-1:0] : div_shift[XLEN-1:0];
                lo  <= {lo[XLEN-2:0], div_ge};
            end
            else
            begin
                acc <= mul_sum[XLEN:1];
                lo  <= {mul_sum[0], lo[XLEN-1:1]};
            end
        end
    end

    // Sign correction on the magnitude results.
    assign prod = neg_q ? -{acc, lo} : {acc, lo};
    assign quo  = neg_q ? -lo : lo;
    assign rem  = rem_neg_q ? -acc : acc;

    always_comb
    begin
        case (op_q)
        exu_pkg::MUL:     o_result = prod[XLEN-1:0];
        exu_pkg::MULH,
        exu_pkg::MULHSU,
        exu_pkg::MULHU:   o_result = prod[2*XLEN-1:XLEN];
        exu_pkg::DIV,
        exu_pkg::DIVU:    o_result = quo;
        exu_pkg::REM,
        exu_pkg::REMU:    o_result = rem;
        default:          o_result = '0;
        endcase
    end

endmodule

/* design/exu_pkg.sv */
`include "exu_defines.svh"

package exu_pkg;

    // ==========================================================
    // Instruction word, R-type and I-type views.
    // ==========================================================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } exu_rtype_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } exu_itype_t;

    typedef union packed {
        exu_rtype_t r;
        exu_itype_t i;
    } exu_instr_u;

    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        ILLEGAL
    } exu_op_e;

    // ==========================================================
    // Stage to stage payloads.
    // ==========================================================
    typedef struct packed {
        logic                 valid;
        exu_instr_u           instr;
        logic [`EXU_XLEN-1:0] op1;
        logic [`EXU_XLEN-1:0] op2;
    } exu_issue_t;

    typedef struct packed {
        logic                 valid;
        exu_op_e              op;
        logic [`EXU_XLEN-1:0] op1;
        logic [`EXU_XLEN-1:0] op2;
    } exu_ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [`EXU_XLEN-1:0] result;
    } exu_res_t;

endpackage

/* design/exu_top.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_top
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [3:0]              i_wb_adr,
    input  logic [`EXU_XLEN-1:0]    i_wb_dat,
    output logic [`EXU_XLEN-1:0]    o_wb_dat,
    output logic                    o_wb_ack
);

    exu_pkg::exu_issue_t    issue;
    exu_pkg::exu_ctrl_t     ctrl;
    exu_pkg::exu_res_t      res;

    exu_wb_slave u_wb_slave
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wb_cyc   (i_wb_cyc),
        .i_wb_stb   (i_wb_stb),
        .i_wb_we    (i_wb_we),
        .i_wb_adr   (i_wb_adr),
        .i_wb_dat   (i_wb_dat),
        .o_wb_dat   (o_wb_dat),
        .o_wb_ack   (o_wb_ack),
        .o_issue    (issue),
        .i_res      (res)
    );

    exu_decode u_decode
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_issue    (issue),
        .o_ctrl     (ctrl)
    );

    exu_execute u_execute
    (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ctrl     (ctrl),
        .o_res      (res)
    );

endmodule

/* design/exu_wb_slave.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_wb_slave
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_wb_cyc,
    input  logic                    i_wb_stb,
    input  logic                    i_wb_we,
    input  logic [3:0]              i_wb_adr,
    input  logic [`EXU_XLEN-1:0]    i_wb_dat,
    output logic [`EXU_XLEN-1:0]    o_wb_dat,
    output logic                    o_wb_ack,
    output exu_pkg::exu_issue_t     o_issue,
    input  exu_pkg::exu_res_t       i_res
);

    logic                   req;
    logic                   ack_next;
    logic                   issue_next;
    logic [`EXU_XLEN-1:0]   rd_next;
    logic                   busy;
    logic                   issue_valid;
    logic [`EXU_XLEN-1:0]   op1_q;
    logic [`EXU_XLEN-1:0]   op2_q;
    logic [`EXU_XLEN-1:0]   result_q;
    exu_pkg::exu_instr_u    instr_q;

    // A request is served once; ack drops before the next one.
    assign req = i_wb_cyc & i_wb_stb & ~o_wb_ack;

    always_comb
    begin
        ack_next   = 1'b0;
        issue_next = 1'b0;
        rd_next    = '0;
        if (req)
        begin
            case (i_wb_adr)
            `EXU_REG_OP1:
            begin
                ack_next = 1'b1;
                rd_next  = op1_q;
            end
            `EXU_REG_OP2:
            begin
                ack_next = 1'b1;
                rd_next  = op2_q;
            end
            `EXU_REG_INSTR:
            begin
                // Back-pressure while an instruction is in flight.
                ack_next   = ~(i_wb_we & busy);
                issue_next = i_wb_we & ~busy;
                rd_next    = instr_q;
            end
            `EXU_REG_RESULT:
            begin
                ack_next = i_wb_we | ~busy;
                rd_next  = result_q;
            end
            default:
                ack_next = 1'b1;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_wb_ack    <= 1'b0;
            issue_valid <= 1'b0;
            busy        <= 1'b0;
            result_q    <= '0;
        end
        else
        begin
            o_wb_ack    <= ack_next;
            issue_valid <= issue_next;
            if (issue_next)
                busy <= 1'b1;
            else if (i_res.valid)
                busy <= 1'b0;
            if (i_res.valid)
                result_q <= i_res.result;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (req && i_wb_we && i_wb_adr == `EXU_REG_OP1)
            op1_q <= i_wb_dat;
        if (req && i_wb_we && i_wb_adr == `EXU_REG_OP2)
            op2_q <= i_wb_dat;
        if (issue_next)
            instr_q <= i_wb_dat;
        if (ack_next)
            o_wb_dat <= rd_next;
    end

    always_comb
    begin
        o_issue.valid = issue_valid;
        o_issue.instr = instr_q;
        o_issue.op1   = op1_q;
        o_issue.op2   = op2_q;
    end

    // The master still holds the strobe when ack comes up.
    a_ack_needs_stb: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_wb_ack) |-> i_wb_cyc && i_wb_stb);

endmodule

/* tb.f */
+incdir+design
+incdir+testbench
design/exu_pkg.sv
design/exu_alu.sv
design/exu_muldiv.sv
design/exu_decode.sv
design/exu_execute.sv
design/exu_wb_slave.sv
design/exu_top.sv
testbench/exu_tb.sv

/* testbench/exu_ref.svh */
`ifndef EXU_REF_SVH
`define EXU_REF_SVH

// Expected result of one instruction, from the RV32I and RV32M rules.
function automatic logic [31:0] expected_result(input logic [31:0] op1,
                                                input logic [31:0] op2,
                                                input logic [31:0] instr);
    logic [6:0]  opcode;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        alt;
    logic        ovf;
    logic [31:0] b;
    logic [63:0] prod;

    opcode = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    ovf    = (op1 == 32'h8000_0000) && (op2 == 32'hffff_ffff);

    // RV32M group.
    if (opcode == 7'h33 && f7 == 7'h01)
    begin
        if (f3 == 3'd1)
            prod = {{32{op1[31]}}, op1} * {{32{op2[31]}}, op2};
        else if (f3 == 3'd2)
            prod = {{32{op1[31]}}, op1} * {32'd0, op2};
        else
            prod = {32'd0, op1} * {32'd0, op2};
        case (f3)
        3'd0:
            return op1 * op2;
        3'd1, 3'd2, 3'd3:
            return prod[63:32];
        3'd4:
        begin
            if (op2 == 32'd0)
                return 32'hffff_ffff;
            if (ovf)
                return op1;
            return $signed(op1) / $signed(op2);
        end
        3'd5:
        begin
            if (op2 == 32'd0)
                return 32'hffff_ffff;
            return op1 / op2;
        end
        3'd6:
        begin
            if (op2 == 32'd0)
                return op1;
            if (ovf)
                return 32'd0;
            return $signed(op1) % $signed(op2);
        end
        default:
        begin
            if (op2 == 32'd0)
                return op1;
            return op1 % op2;
        end
        endcase
    end

    if (opcode == 7'h33)
    begin
        b   = op2;
        alt = (f7 == 7'h20);
        if (f7 != 7'h00 && !(alt && (f3 == 3'd0 || f3 == 3'd5)))
            return 32'd0;
    end
    else if (opcode == 7'h13)
    begin
        b   = {{20{instr[31]}}, instr[31:20]};
        alt = 1'b0;
        if (f3 == 3'd1 || f3 == 3'd5)
        begin
            // Shamt in the low immediate bits, funct7 above it.
            b   = {27'd0, instr[24:20]};
            alt = (f7 == 7'h20);
            if (f7 != 7'h00 && !(alt && f3 == 3'd5))
                return 32'd0;
        end
    end
    else
        return 32'd0;

    case (f3)
    3'd0:
    begin
        if (alt)
            return op1 - b;
        return op1 + b;
    end
    3'd1:
        return op1 << b[4:0];
    3'd2:
        return {31'd0, $signed(op1) < $signed(b)};
    3'd3:
        return {31'd0, op1 < b};
    3'd4:
        return op1 ^ b;
    3'd5:
    begin
        if (alt)
            return $signed(op1) >>> b[4:0];
        return op1 >> b[4:0];
    end
    3'd6:
        return op1 | b;
    default:
        return op1 & b;
    endcase
endfunction

`endif

/* testbench/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_tb;

    localparam int N_RAND = 6;
    localparam int N_IMM  = 8;
    // Operations issued by the stimulus below.
    localparam int N_OPS  = 18 * (9 + N_RAND) + 9 * N_IMM + 5;
    localparam int WATCHDOG_CYCLES = N_OPS * 60 + 16 + 1000;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    logic [3:0]             wb_adr;
    logic [`EXU_XLEN-1:0]   wb_dat_w;
    logic [`EXU_XLEN-1:0]   wb_dat_r;
    logic                   wb_ack;
    logic [31:0]            exp_q[$];
    logic [31:0]            rd_exp_q[$];
    logic [31:0]            rd_act_q[$];
    int                     checks = 0;
    int                     errors = 0;

    `include "exu_ref.svh"

    exu_top u_exu_top
    (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_wb_cyc   (wb_cyc),
        .i_wb_stb   (wb_stb),
        .i_wb_we    (wb_we),
        .i_wb_adr   (wb_adr),
        .i_wb_dat   (wb_dat_w),
        .o_wb_dat   (wb_dat_r),
        .o_wb_ack   (wb_ack)
    );

    always #5 clk = ~clk;

    // ==========================================================
    // Helpers.
    // ==========================================================
    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %s expected 0x%08h actual 0x%08h at %0t", name, exp, act, $time);
        end
    endtask

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3);
        // Register numbers are don't-care for this unit.
        return {f7, 5'($urandom), 5'($urandom), f3, 5'($urandom), 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'($urandom), f3, 5'($urandom), 7'b0010011};
    endfunction

    function automatic logic [31:0] edge_operand(input int k);
        case (k)
        0:       return 32'h0000_0000;
        1:       return 32'hffff_ffff;
        default: return 32'h8000_0000;
        endcase
    endfunction

    task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat, output int waits);
        @(posedge clk);
        // Ack is low out of reset and after every single-cycle pulse.
        compare_value("o_wb_ack", 32'h0, 32'(wb_ack));
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        waits = 0;
        do
        begin
            @(posedge clk);
            waits++;
        end
        while (!wb_ack);
        rdat = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] rdat;
        int          waits;
        bus_cycle(1'b1, adr, data, rdat, waits);
    endtask

    task automatic expect_read(input logic [3:0] adr, input logic [31:0] exp);
        logic [31:0] rdat;
        int          waits;
        bus_cycle(1'b0, adr, 32'h0, rdat, waits);
        rd_exp_q.push_back(exp);
        rd_act_q.push_back(rdat);
    endtask

    task automatic issue_and_check(input logic [31:0] op1, input logic [31:0] op2,
                                   input logic [31:0] instr);
        logic [31:0] exp;
        exp = expected_result(op1, op2, instr);
        write_reg(`EXU_REG_OP1, op1);
        write_reg(`EXU_REG_OP2, op2);
        exp_q.push_back(exp);
        write_reg(`EXU_REG_INSTR, instr);
        expect_read(`EXU_REG_RESULT, exp);
    endtask

    // ==========================================================
    // Stimulus groups.
    // ==========================================================
    task automatic sweep_operands(input logic [31:0] instr);
        for (int a = 0; a < 3; a++)
            for (int b = 0; b < 3; b++)
                issue_and_check(edge_operand(a), edge_operand(b), instr);
        for (int k = 0; k < N_RAND; k++)
            issue_and_check($urandom, $urandom, instr);
    endtask

    task automatic imm_arith_ops();
        logic [2:0]  f3;
        logic [11:0] imm;
        for (int n = 0; n < 8; n++)
        begin
            f3 = 3'(n);
            if (f3 != 3'd1 && f3 != 3'd5)
            begin
                for (int k = 0; k < N_IMM; k++)
                begin
                    imm = 12'($urandom);
                    // Every other immediate is negative.
                    if (k % 2 == 0)
                        imm[11] = 1'b1;
                    issue_and_check($urandom, $urandom, i_type_word(imm, f3));
                end
            end
        end
    endtask

    task automatic imm_shift_ops();
        logic [4:0]  shamt;
        logic [31:0] op1;
        for (int k = 0; k < N_IMM; k++)
        begin
            shamt = 5'($urandom);
            if (k == 0)
                shamt = 5'd31;
            if (k == 1)
                shamt = 5'd0;
            op1 = $urandom;
            if (k % 2 == 0)
                op1[31] = 1'b1;
            issue_and_check(op1, $urandom, i_type_word({7'h00, shamt}, 3'd1));
            issue_and_check(op1, $urandom, i_type_word({7'h00, shamt}, 3'd5));
            issue_and_check(op1, $urandom, i_type_word({7'h20, shamt}, 3'd5));
        end
    endtask

    task automatic back_pressure_case();
        logic [31:0] div_instr;
        logic [31:0] add_instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        logic [31:0] rdat;
        int          waits;
        div_instr = r_type_word(7'h01, 3'd4);
        add_instr = r_type_word(7'h00, 3'd0);
        a = $urandom;
        b = $urandom | 32'h1;
        c = $urandom;
        d = $urandom;
        write_reg(`EXU_REG_OP1, a);
        write_reg(`EXU_REG_OP2, b);
        exp_q.push_back(expected_result(a, b, div_instr));
        write_reg(`EXU_REG_INSTR, div_instr);
        // New operands while the divide is still running.
        write_reg(`EXU_REG_OP1, c);
        write_reg(`EXU_REG_OP2, d);
        exp_q.push_back(expected_result(c, d, add_instr));
        bus_cycle(1'b1, `EXU_REG_INSTR, add_instr, rdat, waits);
        if (waits <= 8)
        begin
            errors++;
            $display("INSTR write was not held back by the running divide (%0d cycles)", waits);
        end
        expect_read(`EXU_REG_RESULT, expected_result(c, d, add_instr));
    endtask

    task automatic illegal_instrs();
        issue_and_check($urandom, $urandom, 32'h1234_50b7);
        issue_and_check($urandom, $urandom, r_type_word(7'h20, 3'd1));
        issue_and_check($urandom, $urandom, i_type_word({7'h20, 5'd3}, 3'd1));
    endtask

    // ==========================================================
    // Compare process.
    // ==========================================================
    always @(posedge clk)
    begin
        if (rst_n && u_exu_top.res.valid)
        begin
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("A result came out with no instruction in flight at %0t", $time);
            end
            else
                compare_value("res.result", exp_q.pop_front(), u_exu_top.res.result);
        end
        while (rd_act_q.size() > 0 && rd_exp_q.size() > 0)
            compare_value("o_wb_dat", rd_exp_q.pop_front(), rd_act_q.pop_front());
    end

    initial
    begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, the DUT stopped answering", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

    initial
    begin : stimulus
        void'($urandom(32'h117e));
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 4'h0;
        wb_dat_w = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        // Reset value and register readback.
        expect_read(`EXU_REG_RESULT, 32'h0);
        write_reg(`EXU_REG_OP1, 32'hdead_beef);
        write_reg(`EXU_REG_OP2, 32'h0bad_f00d);
        expect_read(`EXU_REG_OP1, 32'hdead_beef);
        expect_read(`EXU_REG_OP2, 32'h0bad_f00d);

        for (int n = 0; n < 8; n++)
            sweep_operands(r_type_word(7'h00, 3'(n)));
        sweep_operands(r_type_word(7'h20, 3'd0));
        sweep_operands(r_type_word(7'h20, 3'd5));

        imm_arith_ops();
        imm_shift_ops();

        for (int n = 0; n < 8; n++)
            sweep_operands(r_type_word(7'h01, 3'(n)));

        back_pressure_case();
        illegal_instrs();

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d issued instructions never produced a result", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
